// File: logic/resizer_pkg.sv
package resizer_pkg;

  // smallest unit kept intact through the up/down conversion
  localparam int subword_width = 8;

  // default geometry of the converter
  localparam int default_dwidth_in = 24;
  localparam int default_up = 4;
  localparam int default_down = 3;

  // 4 input words of 24 bits make one 96-bit word, split into 3 words of 32 bits
  localparam int default_num_lanes = 4;

  // lane pointers are sized for at most this many lanes
  localparam int lane_count_max = 16;

  // one subword of payload
  typedef logic [subword_width-1:0] subword_t;

endpackage

// File: logic/stream_if.sv
interface stream_if #(
  parameter int DWIDTH = resizer_pkg::default_dwidth_in
) ();

  // payload and framing
  logic [DWIDTH-1:0] data;
  logic              last;

  // a word moves on a clock edge with both handshake signals high
  logic              valid;
  logic              ready;

  // producer side holds data, last and valid until the transfer
  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  // consumer side only answers with ready
  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

// File: logic/stream_upsizer.sv
module stream_upsizer #(
  parameter int DWIDTH = resizer_pkg::default_dwidth_in,
  parameter int UP = resizer_pkg::default_up
) (
  input logic      clk,
  input logic      reset,
  stream_if.sink   narrow,
  stream_if.source wide
);

  localparam int SLOT_W = (UP > 1) ? $clog2(UP) : 1;

  // partial wide word, slot 0 in the lowest bits
  logic [UP-1:0][DWIDTH-1:0] acc;
  logic [UP-1:0][DWIDTH-1:0] packed_word;
  logic [SLOT_W-1:0]         slot;

  // output register
  logic [UP*DWIDTH-1:0] out_data_q;
  logic                 out_last_q;
  logic                 out_valid_q;

  logic accept;
  logic flush;

  // take input while the output register is empty or drains this cycle
  assign narrow.ready = !out_valid_q || wide.ready;
  assign accept = narrow.valid && narrow.ready;
  assign flush = accept && (narrow.last || slot == SLOT_W'(UP - 1));

  // word as it would look if flushed now; slots past the current one read zero
  always_comb begin
    for (int j = 0; j < UP; j++) begin
      if (j < slot) begin
        packed_word[j] = acc[j];
      end else if (j == slot) begin
        packed_word[j] = narrow.data;
      end else begin
        packed_word[j] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      acc[slot] <= narrow.data;
    end
    if (flush) begin
      out_data_q <= packed_word;
      out_last_q <= narrow.last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      slot <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        slot <= flush ? '0 : slot + 1'b1;
      end
      if (flush) begin
        out_valid_q <= 1'b1;
      end else if (wide.ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  assign wide.data = out_data_q;
  assign wide.last = out_last_q;
  assign wide.valid = out_valid_q;

  // a stalled wide word must not change until the downsizer takes it
  a_wide_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid_q && !wide.ready |=> out_valid_q && $stable(out_data_q) && $stable(out_last_q))
    else $error("upsizer output changed under back-pressure");

  a_subword_fit: assert property (@(posedge clk)
    DWIDTH % resizer_pkg::subword_width == 0)
    else $error("upsizer input width is not a whole number of subwords");

endmodule

// File: logic/stream_downsizer.sv
module stream_downsizer #(
  parameter int DWIDTH = resizer_pkg::default_dwidth_in * resizer_pkg::default_up,
  parameter int DOWN = resizer_pkg::default_down
) (
  input logic      clk,
  input logic      reset,
  stream_if.sink   wide,
  stream_if.source narrow
);

  localparam int NW = DWIDTH / DOWN;
  localparam int IDX_W = (DOWN > 1) ? $clog2(DOWN) : 1;

  logic [DWIDTH-1:0] hold;
  logic              hold_last;
  logic              full;
  logic [IDX_W-1:0]  idx;

  logic final_slice;
  logic final_take;
  logic load;

  assign final_slice = (idx == IDX_W'(DOWN - 1));
  assign final_take = full && narrow.ready && final_slice;
  assign wide.ready = !full || final_take;
  assign load = wide.valid && wide.ready;

  // lowest slice goes out first
  assign narrow.data = hold[idx*NW +: NW];
  assign narrow.valid = full;
  assign narrow.last = hold_last && final_slice;

  always_ff @(posedge clk) begin
    if (load) begin
      hold <= wide.data;
      hold_last <= wide.last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
      idx <= '0;
    end else begin
      if (full && narrow.ready) begin
        idx <= final_slice ? '0 : idx + 1'b1;
        if (final_slice) begin
          full <= 1'b0;
        end
      end
      // a new word may land on the same edge as the final slice leaves
      if (load) begin
        full <= 1'b1;
      end
    end
  end

  // once the last slice is gone and nothing was loaded the lane goes quiet
  a_empty_quiet: assert property (@(posedge clk) disable iff (reset)
    final_take && !load |=> !narrow.valid)
    else $error("downsizer presents data with an empty holding register");

  // first slice one cycle after the wide word was accepted
  a_first_slice: assert property (@(posedge clk) disable iff (reset)
    load |=> narrow.valid && idx == '0)
    else $error("downsizer did not present the first slice");

  a_split_fit: assert property (@(posedge clk)
    DWIDTH % DOWN == 0 && NW % resizer_pkg::subword_width == 0)
    else $error("downsizer width does not split into whole subwords");

endmodule

// File: logic/packet_distributor.sv
module packet_distributor #(
  parameter int DWIDTH = resizer_pkg::default_dwidth_in,
  parameter int NUM_LANES = resizer_pkg::default_num_lanes
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [DWIDTH-1:0] in_data,
  input  logic              in_valid,
  input  logic              in_last,
  output logic              in_ready,
  stream_if.source          lanes [NUM_LANES]
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // lane that receives the current packet
  logic [PTR_W-1:0]     lane_ptr;
  logic [NUM_LANES-1:0] lane_ready;
  logic                 packet_done;

  // every lane sees the same payload, only the pointed one sees valid
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign lanes[i].data = in_data;
    assign lanes[i].last = in_last;
    assign lanes[i].valid = in_valid && (lane_ptr == PTR_W'(i));
    assign lane_ready[i] = lanes[i].ready;
  end

  assign in_ready = lane_ready[lane_ptr];
  assign packet_done = in_valid && in_ready && in_last;

  // step to the next lane once the packet's last word has gone
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_ptr <= '0;
    end else if (packet_done) begin
      if (lane_ptr == PTR_W'(NUM_LANES - 1)) begin
        lane_ptr <= '0;
      end else begin
        lane_ptr <= lane_ptr + 1'b1;
      end
    end
  end

  a_ptr_range: assert property (@(posedge clk) disable iff (reset)
    lane_ptr < NUM_LANES)
    else $error("distributor lane pointer out of range");

  a_lane_bound: assert property (@(posedge clk)
    NUM_LANES <= resizer_pkg::lane_count_max)
    else $error("distributor lane count exceeds the supported maximum");

endmodule

// File: logic/packet_collector.sv
module packet_collector #(
  parameter int DWIDTH = resizer_pkg::default_dwidth_in * resizer_pkg::default_up
                         / resizer_pkg::default_down,
  parameter int NUM_LANES = resizer_pkg::default_num_lanes
) (
  input  logic              clk,
  input  logic              reset,
  stream_if.sink            lanes [NUM_LANES],
  output logic [DWIDTH-1:0] out_data,
  output logic              out_valid,
  output logic              out_last,
  input  logic              out_ready
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // lane whose packet is currently being drained
  logic [PTR_W-1:0] lane_ptr;

  // lane outputs gathered so the pointer can select among them
  logic [NUM_LANES-1:0][DWIDTH-1:0] lane_data;
  logic [NUM_LANES-1:0]             lane_valid;
  logic [NUM_LANES-1:0]             lane_last;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign lane_data[i] = lanes[i].data;
    assign lane_valid[i] = lanes[i].valid;
    assign lane_last[i] = lanes[i].last;
    // other lanes are held off until their turn
    assign lanes[i].ready = out_ready && (lane_ptr == PTR_W'(i));
  end

  assign out_data = lane_data[lane_ptr];
  assign out_valid = lane_valid[lane_ptr];
  assign out_last = lane_last[lane_ptr];

  // same rotation as the distributor keeps packets in arrival order
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_ptr <= '0;
    end else if (out_valid && out_ready && out_last) begin
      if (lane_ptr == PTR_W'(NUM_LANES - 1)) begin
        lane_ptr <= '0;
      end else begin
        lane_ptr <= lane_ptr + 1'b1;
      end
    end
  end

  a_valid_source: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> lane_ptr < NUM_LANES && lane_valid[lane_ptr])
    else $error("collector output valid without a valid lane");

  // the lane behind the mux must keep its word until it is taken
  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else $error("collector output changed under back-pressure");

  a_lane_bound: assert property (@(posedge clk)
    NUM_LANES <= resizer_pkg::lane_count_max)
    else $error("collector lane count exceeds the supported maximum");

endmodule

// File: logic/resizer_array.sv
module resizer_array #(
  parameter int DWIDTH_IN = resizer_pkg::default_dwidth_in,
  parameter int UP = resizer_pkg::default_up,
  parameter int DOWN = resizer_pkg::default_down,
  parameter int NUM_LANES = resizer_pkg::default_num_lanes
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [DWIDTH_IN-1:0]           in_data,
  input  logic                           in_valid,
  input  logic                           in_last,
  output logic                           in_ready,
  output logic [DWIDTH_IN*UP/DOWN-1:0]   out_data,
  output logic                           out_valid,
  output logic                           out_last,
  input  logic                           out_ready
);

  localparam int WIDE_W = DWIDTH_IN * UP;
  localparam int OUT_W = WIDE_W / DOWN;

  // narrow, packed wide and resized streams of each lane
  stream_if #(.DWIDTH(DWIDTH_IN)) lane_in   [NUM_LANES] ();
  stream_if #(.DWIDTH(WIDE_W))    lane_wide [NUM_LANES] ();
  stream_if #(.DWIDTH(OUT_W))     lane_out  [NUM_LANES] ();

  packet_distributor #(
    .DWIDTH(DWIDTH_IN),
    .NUM_LANES(NUM_LANES)
  ) packet_distributor_inst (
    .clk,
    .reset,
    .in_data,
    .in_valid,
    .in_last,
    .in_ready,
    .lanes(lane_in)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    stream_upsizer #(
      .DWIDTH(DWIDTH_IN),
      .UP(UP)
    ) stream_upsizer_inst (
      .clk,
      .reset,
      .narrow(lane_in[i]),
      .wide(lane_wide[i])
    );

    stream_downsizer #(
      .DWIDTH(WIDE_W),
      .DOWN(DOWN)
    ) stream_downsizer_inst (
      .clk,
      .reset,
      .wide(lane_wide[i]),
      .narrow(lane_out[i])
    );
  end

  packet_collector #(
    .DWIDTH(OUT_W),
    .NUM_LANES(NUM_LANES)
  ) packet_collector_inst (
    .clk,
    .reset,
    .lanes(lane_out),
    .out_data,
    .out_valid,
    .out_last,
    .out_ready
  );

endmodule

// File: testbench/resizer_array_tb.sv
module resizer_array_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SW = resizer_pkg::subword_width;
  localparam int DWIDTH_IN = resizer_pkg::default_dwidth_in;
  localparam int UP = resizer_pkg::default_up;
  localparam int DOWN = resizer_pkg::default_down;
  localparam int OUT_W = DWIDTH_IN * UP / DOWN;
  localparam int IN_BYTES = DWIDTH_IN / SW;
  localparam int GROUP_BYTES = DWIDTH_IN * UP / SW;
  localparam int OUT_BYTES = OUT_W / SW;

  typedef logic [DWIDTH_IN-1:0] in_q_t [$];
  typedef resizer_pkg::subword_t [OUT_BYTES-1:0] out_word_t;

  logic                 clk = 1'b0;
  logic                 reset;
  logic [DWIDTH_IN-1:0] in_data;
  logic                 in_valid;
  logic                 in_last;
  logic                 in_ready;
  logic [OUT_W-1:0]     out_data;
  logic                 out_valid;
  logic                 out_last;
  logic                 out_ready;

  // expected output words, oldest first
  out_word_t exp_data [$];
  logic      exp_last [$];

  int errors = 0;
  int passes = 0;
  int test_start_errors = 0;
  int words_sent = 0;
  // 0 holds out_ready high, 1 toggles it randomly, 2 holds it low
  int ready_mode = 0;
  logic [31:0] stim_rng = 32'h8c2d;
  logic [31:0] ready_rng = 32'h8c2d;

  resizer_array resizer_array_inst (
    .clk,
    .reset,
    .in_data,
    .in_valid,
    .in_last,
    .in_ready,
    .out_data,
    .out_valid,
    .out_last,
    .out_ready
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // bytes of the packet in order, zero padded to whole wide words, regrouped
  function automatic void expected_words(input in_q_t pkt);
    resizer_pkg::subword_t bytes [$];
    out_word_t word;
    int n_out;
    foreach (pkt[i]) begin
      for (int b = 0; b < IN_BYTES; b++) begin
        bytes.push_back(pkt[i][b*SW +: SW]);
      end
    end
    while (bytes.size() % GROUP_BYTES != 0) begin
      bytes.push_back('0);
    end
    n_out = bytes.size() / OUT_BYTES;
    for (int w = 0; w < n_out; w++) begin
      for (int b = 0; b < OUT_BYTES; b++) begin
        word[b] = bytes[w*OUT_BYTES + b];
      end
      exp_data.push_back(word);
      exp_last.push_back(w == n_out - 1);
    end
  endfunction

  task automatic check_word(input out_word_t got, input out_word_t exp);
    if (got !== exp) begin
      $display("error at %0t: out_data %h, expected %h", $time, got, exp);
      errors++;
    end else begin
      passes++;
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: out_last %b, expected %b", $time, got, exp);
      errors++;
    end else begin
      passes++;
    end
  endtask

  // valid stays up after the final word so the next packet can follow back to back
  task automatic send_packet(input int len, input bit gaps);
    in_q_t pkt;
    int idle;
    for (int i = 0; i < len; i++) begin
      stim_rng = xorshift(stim_rng);
      pkt.push_back(stim_rng[DWIDTH_IN-1:0]);
    end
    expected_words(pkt);
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      idle = 0;
      if (gaps) begin
        stim_rng = xorshift(stim_rng);
        idle = int'(stim_rng % 4);
      end
      if (idle != 0) begin
        in_valid = 1'b0;
        repeat (idle) @(negedge clk);
      end
      in_data = pkt[i];
      in_last = (i == len - 1);
      in_valid = 1'b1;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      words_sent++;
    end
  endtask

  task automatic stop_input();
    @(negedge clk);
    in_valid = 1'b0;
    in_last = 1'b0;
  endtask

  task automatic finish_test(input int num, input string name);
    while (exp_data.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    if (errors == test_start_errors) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  always @(negedge clk) begin
    ready_rng = xorshift(ready_rng);
    case (ready_mode)
      1: out_ready = ready_rng[7];
      2: out_ready = 1'b0;
      default: out_ready = 1'b1;
    endcase
  end

  // compare every transferred output word with the reference
  always @(posedge clk) begin
    if (!reset && out_valid && out_ready) begin
      if (exp_data.size() == 0) begin
        $display("error at %0t: output word %h with no packet outstanding", $time, out_data);
        errors++;
      end else begin
        check_word(out_data, exp_data.pop_front());
        check_last(out_last, exp_last.pop_front());
      end
    end
  end

  // limit grows with the traffic sent so far
  initial begin : watchdog
    longint limit;
    limit = 2000;
    while ($time <= limit) begin
      #100;
      limit = longint'(words_sent) * 40 * 8 + 2000;
    end
    $display("timeout at %0t: the output stalled with %0d words still expected",
             $time, exp_data.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    int len;
    int low_cycles;
    reset = 1'b1;
    in_data = '0;
    in_valid = 1'b0;
    in_last = 1'b0;
    out_ready = 1'b1;

    // nothing may come out during or after reset without input
    repeat (4) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        $display("error at %0t: out_valid high during reset", $time);
        errors++;
      end
    end
    reset = 1'b0;
    repeat (8) begin
      @(posedge clk);
      if (out_valid !== 1'b0) begin
        $display("error at %0t: out_valid high before any input", $time);
        errors++;
      end
    end
    finish_test(1, "reset state");

    send_packet(4, 1'b0);
    send_packet(8, 1'b0);
    send_packet(12, 1'b0);
    send_packet(16, 1'b0);
    send_packet(40, 1'b0);
    stop_input();
    finish_test(2, "full packets");

    for (int n = 1; n < 8; n++) begin
      if (n % UP != 0) begin
        send_packet(n, 1'b0);
      end
    end
    stop_input();
    finish_test(3, "partial packets");

    repeat (30) send_packet(1, 1'b0);
    stop_input();
    finish_test(4, "lane rotation");

    ready_mode = 1;
    repeat (20) begin
      stim_rng = xorshift(stim_rng);
      len = int'(stim_rng % 40) + 1;
      send_packet(len, 1'b1);
    end
    stop_input();
    finish_test(5, "back-pressure and gaps");

    // more packets than lanes while the output is blocked
    ready_mode = 2;
    repeat (2) @(negedge clk);
    fork
      begin
        repeat (6) send_packet(8, 1'b0);
        stop_input();
      end
      begin
        low_cycles = 0;
        for (int c = 0; c < 400 && low_cycles < 20; c++) begin
          @(posedge clk);
          if (in_valid && !in_ready) begin
            low_cycles++;
          end else begin
            low_cycles = 0;
          end
        end
        if (low_cycles < 20) begin
          $display("in_ready never fell while out_ready was held low");
          errors++;
        end
        ready_mode = 0;
      end
    join
    finish_test(6, "long stall");

    $display("checks passed %0d, errors %0d", passes, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
logic/resizer_pkg.sv
logic/stream_if.sv
logic/stream_upsizer.sv
logic/stream_downsizer.sv
logic/packet_distributor.sv
logic/packet_collector.sv
logic/resizer_array.sv
testbench/resizer_array_tb.sv
